//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f dmisscam.f --top-module dmisscam_tb
	@out="$$(./obj_dir/Vdmisscam_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- dmisscam.f
+incdir+tb
hw/dmiss_pkg.sv
hw/dmiss_req_stage.sv
hw/dmiss_alloc.sv
hw/dmiss_buf.sv
hw/dmiss_replay.sv
hw/dmisscam.sv
tb/dmisscam_tb.sv

//--- hw/dmiss_alloc.sv
`timescale 1ns/1ns

module dmiss_alloc (
  input  dmiss_pkg::port_vec_t                           stage_valid_i,
  input  dmiss_pkg::buf_vec_t                            busy_i,
  input  logic                                           locked_i,
  output dmiss_pkg::buf_vec_t [dmiss_pkg::NUM_PORTS-1:0] grant_o
);

  import dmiss_pkg::*;

  logic [BUF_IDX_W:0] free_cnt;
  logic [BUF_IDX_W:0] rank;  // Valid ports below the current one.
  buf_vec_t           taken;
  buf_vec_t           avail;

  always_comb begin
    free_cnt = '0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      free_cnt = free_cnt + {{BUF_IDX_W{1'b0}}, ~busy_i[b]};
    end
  end

  // Ports in ascending order take the lowest buffers left over.
  always_comb begin
    rank = '0;
    taken = '0;
    avail = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      avail = ~busy_i & ~taken;
      grant_o[p] = '0;
      if (stage_valid_i[p] && !locked_i && free_cnt > rank) begin
        grant_o[p] = avail & (~avail + 1'b1);  // Lowest set bit.
        // Count gate must leave the search a free, untaken buffer.
        assert ($onehot(grant_o[p]));
      end
      taken = taken | grant_o[p];
      rank = rank + {{BUF_IDX_W{1'b0}}, stage_valid_i[p]};
    end
  end

endmodule

//--- hw/dmiss_buf.sv
`timescale 1ns/1ns

module dmiss_buf (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             fill_i,
  input  dmiss_pkg::miss_req_t                             fill_req_i,
  input  dmiss_pkg::line_addr_t [dmiss_pkg::NUM_PORTS-1:0] cmp_addr_i,
  input  logic                                             ins_hit_i,
  input  logic                                             issue_i,
  input  logic                                             unlock_i,
  output dmiss_pkg::port_vec_t                             match_o,
  output dmiss_pkg::miss_req_t                             req_o,
  output logic                                             busy_o,
  output logic                                             pending_o,
  output logic                                             issued_o
);

  import dmiss_pkg::*;

  // CAM compare, one per request port.
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      match_o[p] = busy_o && cmp_addr_i[p] == req_o.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o <= 1'b0;
      pending_o <= 1'b0;
      issued_o <= 1'b0;
    end else if (fill_i) begin
      busy_o <= 1'b1;
      pending_o <= 1'b1;
      issued_o <= 1'b0;
    end else if (unlock_i) begin
      busy_o <= 1'b0;
      pending_o <= 1'b0;
      issued_o <= 1'b0;
    end else begin
      if (ins_hit_i) begin
        pending_o <= 1'b0;  // Line arrived.
      end
      if (issue_i) begin
        issued_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i) begin
      req_o <= fill_req_i;
    end
  end

  // Allocator must only pick free buffers.
  assert property (@(posedge clk) disable iff (rst) fill_i |-> !busy_o);

endmodule

//--- hw/dmiss_pkg.sv
package dmiss_pkg;

  localparam int NUM_PORTS = 4;
  localparam int NUM_BUFS = 8;
  localparam int BUF_IDX_W = 3;
  localparam int LINE_ADDR_W = 36;
  localparam int SIZE_W = 5;
  localparam int BANK_W = 5;

  typedef logic [BUF_IDX_W-1:0] buf_idx_t;
  typedef logic [NUM_BUFS-1:0] buf_vec_t;
  typedef logic [NUM_PORTS-1:0] port_vec_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // Payload kept with each outstanding miss.
  typedef struct packed {
    logic              st;     // Store miss.
    logic              dupl;
    logic [SIZE_W-1:0] size;
    logic              odd;
    logic              io;     // Uncached access.
    logic              split;  // Access spans two lines.
    logic [BANK_W-1:0] bank;
    logic [1:0]        low;
  } miss_attr_t;

  typedef struct packed {
    line_addr_t addr;
    miss_attr_t attr;
  } miss_req_t;

  typedef miss_req_t [NUM_PORTS-1:0] req_vec_t;

endpackage

//--- hw/dmiss_replay.sv
`timescale 1ns/1ns

module dmiss_replay (
  input  logic                 clk,
  input  logic                 rst,
  input  dmiss_pkg::buf_vec_t  busy_i,
  input  dmiss_pkg::buf_vec_t  pending_i,
  input  dmiss_pkg::buf_vec_t  issued_i,
  input  logic                 alloc_any_i,
  input  logic                 unlock_i,
  output dmiss_pkg::buf_vec_t  issue_o,
  output logic                 read_valid_o,
  output dmiss_pkg::buf_idx_t  read_idx_o,
  output logic                 has_free_o,
  output logic                 locked_o,
  output logic                 begin_replay_o
);

  import dmiss_pkg::*;

  buf_vec_t ready;
  logic     started;  // Misses allocated since last replay.

  assign ready = busy_i & pending_i & ~issued_i;
  assign issue_o = ready & (~ready + 1'b1);  // Lowest ready buffer.
  assign read_valid_o = |ready;

  always_comb begin
    read_idx_o = '0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      if (issue_o[b]) begin
        read_idx_o = buf_idx_t'(b);
      end
    end
  end

  assign has_free_o = ~&busy_i;
  assign begin_replay_o = started && !(|(busy_i & pending_i));

  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
    end else if (unlock_i) begin
      started <= 1'b0;
    end else if (alloc_any_i) begin
      started <= 1'b1;
    end else if (begin_replay_o) begin
      started <= 1'b0;  // Makes replay a single pulse.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_o <= 1'b0;
    end else if (unlock_i) begin
      locked_o <= 1'b0;
    end else if (!has_free_o || begin_replay_o) begin
      locked_o <= 1'b1;
    end
  end

endmodule

//--- hw/dmiss_req_stage.sv
`timescale 1ns/1ns

module dmiss_req_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  dmiss_pkg::port_vec_t req_valid_i,
  input  dmiss_pkg::req_vec_t  req_i,
  input  dmiss_pkg::port_vec_t held_match_i,
  output dmiss_pkg::port_vec_t stage_valid_o,
  output dmiss_pkg::req_vec_t  stage_req_o,
  output dmiss_pkg::port_vec_t stage_addr_match_o
);

  import dmiss_pkg::*;

  port_vec_t later_dup;  // Same line on a higher port this cycle.
  port_vec_t keep;

  always_comb begin
    later_dup = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = p + 1; q < NUM_PORTS; q++) begin
        if (req_valid_i[q] && req_i[q].addr == req_i[p].addr) begin
          later_dup[p] = 1'b1;
        end
      end
    end
  end

  // Lines still sitting in the stage, not yet in a buffer.
  always_comb begin
    stage_addr_match_o = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (stage_valid_o[q] && stage_req_o[q].addr == req_i[p].addr) begin
          stage_addr_match_o[p] = 1'b1;
        end
      end
    end
  end

  assign keep = req_valid_i & ~later_dup & ~held_match_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid_o <= '0;
    end else begin
      stage_valid_o <= keep;
    end
  end

  always_ff @(posedge clk) begin
    stage_req_o <= req_i;
  end

  // At most one stage entry per line.
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_uniq_p
    for (genvar q = p + 1; q < NUM_PORTS; q++) begin : g_uniq_q
      assert property (@(posedge clk) disable iff (rst)
        !(stage_valid_o[p] && stage_valid_o[q] &&
          stage_req_o[p].addr == stage_req_o[q].addr));
    end
  end

endmodule

//--- hw/dmisscam.sv
`timescale 1ns/1ns

module dmisscam (
  input  logic                  clk,
  input  logic                  rst,
  input  dmiss_pkg::port_vec_t  req_valid_i,
  input  dmiss_pkg::req_vec_t   req_i,
  output logic                  read_valid_o,
  output dmiss_pkg::miss_req_t  read_o,
  output dmiss_pkg::buf_idx_t   read_idx_o,
  input  logic                  ins_en_i,
  input  dmiss_pkg::buf_idx_t   ins_idx_i,
  output dmiss_pkg::line_addr_t ins_addr_o,
  output logic                  has_free_o,
  output logic                  locked_o,
  output logic                  begin_replay_o,
  input  logic                  unlock_i
);

  import dmiss_pkg::*;

  port_vec_t                  stage_valid;
  req_vec_t                   stage_req;
  port_vec_t                  stage_addr_match;
  port_vec_t                  held_match;
  port_vec_t [NUM_BUFS-1:0]   buf_match;
  line_addr_t [NUM_PORTS-1:0] req_addr;
  buf_vec_t [NUM_PORTS-1:0]   grant;
  buf_vec_t                   fill;
  buf_vec_t                   busy;
  buf_vec_t                   pending;
  buf_vec_t                   issued;
  buf_vec_t                   issue;
  miss_req_t [NUM_BUFS-1:0]   fill_req;
  miss_req_t [NUM_BUFS-1:0]   buf_req;

  // Held means in a buffer or still in the stage.
  always_comb begin
    held_match = stage_addr_match;
    for (int p = 0; p < NUM_PORTS; p++) begin
      req_addr[p] = req_i[p].addr;
      for (int b = 0; b < NUM_BUFS; b++) begin
        if (buf_match[b][p]) begin
          held_match[p] = 1'b1;
        end
      end
    end
  end

  // Route each granted stage entry to its buffer.
  always_comb begin
    fill = '0;
    fill_req = '0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (grant[p][b]) begin
          fill[b] = 1'b1;
          fill_req[b] = stage_req[p];
        end
      end
    end
  end

  assign read_o = buf_req[read_idx_o];
  assign ins_addr_o = buf_req[ins_idx_i].addr;

  dmiss_req_stage u_req_stage (
    .clk                (clk),
    .rst                (rst),
    .req_valid_i        (req_valid_i),
    .req_i              (req_i),
    .held_match_i       (held_match),
    .stage_valid_o      (stage_valid),
    .stage_req_o        (stage_req),
    .stage_addr_match_o (stage_addr_match)
  );

  dmiss_alloc u_alloc (
    .stage_valid_i (stage_valid),
    .busy_i        (busy),
    .locked_i      (locked_o),
    .grant_o       (grant)
  );

  for (genvar b = 0; b < NUM_BUFS; b++) begin : g_buf
    dmiss_buf u_buf (
      .clk        (clk),
      .rst        (rst),
      .fill_i     (fill[b]),
      .fill_req_i (fill_req[b]),
      .cmp_addr_i (req_addr),
      .ins_hit_i  (ins_en_i && ins_idx_i == buf_idx_t'(b)),
      .issue_i    (issue[b]),
      .unlock_i   (unlock_i),
      .match_o    (buf_match[b]),
      .req_o      (buf_req[b]),
      .busy_o     (busy[b]),
      .pending_o  (pending[b]),
      .issued_o   (issued[b])
    );
  end

  dmiss_replay u_replay (
    .clk            (clk),
    .rst            (rst),
    .busy_i         (busy),
    .pending_i      (pending),
    .issued_i       (issued),
    .alloc_any_i    (|fill),
    .unlock_i       (unlock_i),
    .issue_o        (issue),
    .read_valid_o   (read_valid_o),
    .read_idx_o     (read_idx_o),
    .has_free_o     (has_free_o),
    .locked_o       (locked_o),
    .begin_replay_o (begin_replay_o)
  );

endmodule

//--- tb/dmisscam_tb_table.svh
// Each row gives the valid mask, address low bytes (port 3 .. port 0), cycles, insert, unlock,
// insert index, ports read, first read index, replay pulse, and locked and has_free at row end.
row_t rows [18] = '{
  // Single misses read lowest index first.
  '{4'b0001, 32'h00_00_00_10, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0001, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b1010, 32'h13_00_11_00, 2'd1, 1'b0, 1'b0, 3'd0, 4'b1010, 3'd1, 1'b0, 1'b0, 1'b1},
  // Same line on ports 0 and 2.
  '{4'b0101, 32'h00_20_00_20, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0100, 3'd3, 1'b0, 1'b0, 1'b1},
  // Lines already held.
  '{4'b0010, 32'h00_00_10_00, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0001, 32'h00_00_00_30, 2'd2, 1'b0, 1'b0, 3'd0, 4'b0001, 3'd4, 1'b0, 1'b0, 1'b1},
  '{4'b1000, 32'h30_00_00_00, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  // The last insert starts replay.
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b1, 1'b0, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b1, 1'b0, 3'd1, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b1, 1'b0, 3'd2, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b1, 1'b0, 3'd3, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b1, 1'b0, 3'd4, 4'b0000, 3'd0, 1'b1, 1'b1, 1'b1},
  // Nothing allocated while locked.
  '{4'b1111, 32'h43_42_41_40, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b1},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b0, 1'b1, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  // Fill all eight buffers.
  '{4'b1111, 32'h53_52_51_50, 2'd1, 1'b0, 1'b0, 3'd0, 4'b1111, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b1111, 32'h57_56_55_54, 2'd1, 1'b0, 1'b0, 3'd0, 4'b1111, 3'd4, 1'b0, 1'b1, 1'b0},
  '{4'b0001, 32'h00_00_00_58, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b1, 1'b0},
  '{4'b0000, 32'h00_00_00_00, 2'd1, 1'b0, 1'b1, 3'd0, 4'b0000, 3'd0, 1'b0, 1'b0, 1'b1},
  '{4'b0100, 32'h00_58_00_00, 2'd1, 1'b0, 1'b0, 3'd0, 4'b0100, 3'd0, 1'b0, 1'b0, 1'b1}
};

//--- tb/dmisscam_tb.sv
`timescale 1ns/1ns

module dmisscam_tb;

  import dmiss_pkg::*;

  typedef struct packed {
    port_vec_t   valid;
    logic [31:0] tags;      // Low address byte per port with port 3 on top.
    logic [1:0]  cycles;    // Same requests held this many cycles.
    logic        ins;
    logic        unlock;
    buf_idx_t    ins_idx;
    port_vec_t   rd_ports;  // Ports whose requests come out as reads.
    buf_idx_t    rd_idx;    // Buffer of the first read.
    logic        replay;
    logic        locked;
    logic        has_free;
  } row_t;

  `include "dmisscam_tb_table.svh"

  logic       clk = 1'b0;
  logic       rst;
  port_vec_t  req_valid_i;
  req_vec_t   req_i;
  logic       read_valid_o;
  miss_req_t  read_o;
  buf_idx_t   read_idx_o;
  logic       ins_en_i;
  buf_idx_t   ins_idx_i;
  line_addr_t ins_addr_o;
  logic       has_free_o;
  logic       locked_o;
  logic       begin_replay_o;
  logic       unlock_i;

  logic [27:0] addr_base;  // Upper line address bits shared by all rows.
  line_addr_t  exp_addr [NUM_BUFS];
  int          replay_seen;

  always #50 clk = ~clk;

  dmisscam dmisscam_i (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .read_valid_o   (read_valid_o),
    .read_o         (read_o),
    .read_idx_o     (read_idx_o),
    .ins_en_i       (ins_en_i),
    .ins_idx_i      (ins_idx_i),
    .ins_addr_o     (ins_addr_o),
    .has_free_o     (has_free_o),
    .locked_o       (locked_o),
    .begin_replay_o (begin_replay_o),
    .unlock_i       (unlock_i)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_req(input miss_req_t got, input miss_req_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_idx(input buf_idx_t got, input buf_idx_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input line_addr_t got, input line_addr_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // Outputs are looked at mid-cycle only.
  task automatic step_negedge();
    @(negedge clk);
    if (begin_replay_o) begin
      replay_seen++;
    end
  endtask

  task automatic wait_read();
    int waited;
    waited = 0;
    step_negedge();
    while (!read_valid_o) begin
      if (waited == 12) begin
        abort_run($sformatf("Timeout at %0t: an expected read never came out", $time));
      end
      waited++;
      step_negedge();
    end
  endtask

  task automatic drive_row(input row_t row, output req_vec_t drv);
    logic [31:0] rnd;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rnd = $urandom();
      drv[p].addr = {addr_base, row.tags[p*8 +: 8]};
      drv[p].attr = rnd[16:0];
    end
    req_valid_i = row.valid;
    req_i = drv;
    ins_en_i = row.ins;
    ins_idx_i = row.ins_idx;
    unlock_i = row.unlock;
  endtask

  task automatic idle_inputs();
    req_valid_i = '0;
    ins_en_i = 1'b0;
    unlock_i = 1'b0;
  endtask

  task automatic run_row(input int n, input row_t row);
    req_vec_t drv;
    buf_idx_t idx;
    replay_seen = 0;
    @(posedge clk);
    #1;
    drive_row(row, drv);
    if (row.ins) begin
      step_negedge();
      check_addr(ins_addr_o, exp_addr[row.ins_idx], $sformatf("row %0d ins_addr_o", n));
    end
    repeat (row.cycles) @(posedge clk);
    #1;
    idle_inputs();
    idx = row.rd_idx;
    // Lower ports sit in lower buffers, so reads follow port order.
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (row.rd_ports[p]) begin
        wait_read();
        check_idx(read_idx_o, idx, $sformatf("row %0d read_idx_o", n));
        check_req(read_o, drv[p], $sformatf("row %0d read_o", n));
        exp_addr[idx] = drv[p].addr;
        idx = idx + 3'd1;
      end
    end
    repeat (4) begin
      step_negedge();
      check_flag(read_valid_o, 1'b0, $sformatf("row %0d extra read_valid_o", n));
    end
    check_flag(replay_seen != 0, row.replay, $sformatf("row %0d begin_replay_o", n));
    if (replay_seen > 1) begin
      abort_run($sformatf("Row %0d: begin_replay_o stayed high for more than one cycle", n));
    end
    check_flag(locked_o, row.locked, $sformatf("row %0d locked_o", n));
    check_flag(has_free_o, row.has_free, $sformatf("row %0d has_free_o", n));
  endtask

  initial begin
    logic [31:0] rnd;
    rnd = $urandom(32'h280f);
    rnd = $urandom();
    addr_base = rnd[27:0];
    rst = 1'b1;
    req_valid_i = '0;
    req_i = '0;
    ins_en_i = 1'b0;
    ins_idx_i = '0;
    unlock_i = 1'b0;
    replay_seen = 0;
    for (int b = 0; b < NUM_BUFS; b++) begin
      exp_addr[b] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_flag(read_valid_o, 1'b0, "read_valid_o after reset");
    check_flag(begin_replay_o, 1'b0, "begin_replay_o after reset");
    check_flag(locked_o, 1'b0, "locked_o after reset");
    check_flag(has_free_o, 1'b1, "has_free_o after reset");
    for (int i = 0; i < $size(rows); i++) begin
      run_row(i, rows[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule
